// ==== tb.f ====
verilog/video_pkg.sv
verilog/sync_fifo.sv
verilog/video_sampler.sv
verilog/frame_writer.sv
verilog/command_decoder.sv
verilog/video_capture_top.sv
test/tb_video_capture.sv

// ==== Makefile ====
# Verilator simulation of the capture testbench

all: run

build:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_video_capture \
		-Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_video_capture

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== test/tb_video_capture.sv ====
// testbench for the capture top level, runs table-driven video and command tests against a word model
`timescale 1ns/100ps

module tb_video_capture;

    // de-low cycles after each line
    localparam int GAP = 3;

    typedef struct packed {
        int frames;
        int lines;
        int pixels;
        int cams;
        int ready_pct;
        int exp_ovf;
    } video_test_t;

    typedef struct packed {
        video_pkg::cmd_t cmd;
        logic [2:0]      exp_channel;
        logic [8:0]      exp_angle;
    } cmd_test_t;

    // frames, lines, pixels per line, camera mask, mem_ready percent, expected overflow mask
    video_test_t video_tests [5] = '{
        '{1, 8, 32, 1, 100, 0},
        '{1, 12, 40, 3, 100, 0},
        '{2, 5, 10, 2, 100, 0},
        '{2, 8, 24, 3, 60, 0},
        '{1, 16, 64, 1, 0, 1}
    };

    // command, then channel_index and angle_num expected after it
    cmd_test_t cmd_tests [7] = '{
        '{'{1'b1, video_pkg::CMD_FOCUS, 4'd5}, 3'd5, 9'd0},
        '{'{1'b1, video_pkg::CMD_FOCUS, 4'd0}, 3'd5, 9'd0},
        '{'{1'b1, 4'h7, 4'd1}, 3'd5, 9'd0},
        '{'{1'b1, video_pkg::CMD_ROTATE, 4'd1}, 3'd5, 9'd180},
        '{'{1'b0, video_pkg::CMD_FOCUS, 4'd2}, 3'd5, 9'd180},
        '{'{1'b1, video_pkg::CMD_ROTATE, 4'd0}, 3'd5, 9'd0},
        '{'{1'b1, video_pkg::CMD_FOCUS, 4'd3}, 3'd3, 9'd0}
    };

    logic                 sys_clk;
    logic                 sys_rst;
    video_pkg::video_in_t cam0;
    video_pkg::video_in_t cam1;
    video_pkg::cmd_t      cmd;
    video_pkg::mem_wr_t   mem_wr;
    logic                 mem_valid;
    logic                 mem_ready;
    logic                 overflow0;
    logic                 overflow1;
    logic [2:0]           channel_index;
    logic [8:0]           angle_num;

    integer               seed = 32'hf1f5_6fb3;
    int                   errors;
    int                   ready_pct;
    video_pkg::mem_wr_t   exp_q0 [$];
    video_pkg::mem_wr_t   exp_q1 [$];
    // model state per channel
    video_pkg::pix_word_t group [2];
    int                   group_cnt [2];
    int                   word_idx [2];
    logic                 prev_valid;
    logic                 prev_ready;
    video_pkg::mem_wr_t   prev_wr;

    video_capture_top i_video_capture_top (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .cam0          (cam0),
        .cam1          (cam1),
        .cmd           (cmd),
        .mem_wr        (mem_wr),
        .mem_valid     (mem_valid),
        .mem_ready     (mem_ready),
        .overflow0     (overflow0),
        .overflow1     (overflow1),
        .channel_index (channel_index),
        .angle_num     (angle_num)
    );

    always #2 sys_clk = ~sys_clk;

    // one cycle, inputs change 1 ns after the edge
    task automatic step();
        @(posedge sys_clk);
        #1;
        mem_ready = (($random(seed) & 32'h7fff_ffff) % 100) < ready_pct;
    endtask

    // collect a kept pixel, a full group becomes one expected word
    task automatic keep_pixel(input int ch, input video_pkg::pix_t pix);
        video_pkg::mem_wr_t wr;
        group[ch][group_cnt[ch]*16 +: 16] = pix;
        group_cnt[ch]++;
        if (group_cnt[ch] == video_pkg::PIX_PER_WORD) begin
            wr.addr = (ch == 0) ? video_pkg::CH0_BASE : video_pkg::CH1_BASE;
            wr.addr = wr.addr + video_pkg::ADDR_W'(word_idx[ch]);
            wr.data = group[ch];
            if (ch == 0) begin
                exp_q0.push_back(wr);
            end else begin
                exp_q1.push_back(wr);
            end
            group_cnt[ch] = 0;
            word_idx[ch]++;
        end
    endtask

    task automatic drive_frame(input video_test_t t);
        video_pkg::pix_t pix0;
        video_pkg::pix_t pix1;
        bit              keep;
        // an unfinished group of the last frame is never written
        for (int c = 0; c < 2; c++) begin
            group_cnt[c] = 0;
            word_idx[c] = 0;
        end
        for (int i = 0; i < 4; i++) begin
            step();
            cam0.de = 1'b0;
            cam1.de = 1'b0;
            cam0.vsync = t.cams[0] && i < 2;
            cam1.vsync = t.cams[1] && i < 2;
        end
        for (int l = 0; l < t.lines; l++) begin
            for (int p = 0; p < t.pixels + GAP; p++) begin
                step();
                pix0 = 16'($random(seed));
                pix1 = 16'($random(seed));
                keep = p < t.pixels && l % video_pkg::DECIM == 0 && p % video_pkg::DECIM == 0;
                cam0.de = t.cams[0] && p < t.pixels;
                cam1.de = t.cams[1] && p < t.pixels;
                cam0.pix = pix0;
                cam1.pix = pix1;
                if (keep && t.cams[0]) begin
                    keep_pixel(0, pix0);
                end
                if (keep && t.cams[1]) begin
                    keep_pixel(1, pix1);
                end
            end
        end
    endtask

    // wait until all expected words are written or the port stays idle
    task automatic drain(input bit lossy);
        int idle;
        idle = 0;
        if (lossy) begin
            ready_pct = 100;
        end
        while (exp_q0.size() + exp_q1.size() != 0 && idle < 64) begin
            step();
            idle = mem_valid ? 0 : idle + 1;
        end
        if (!lossy && exp_q0.size() + exp_q1.size() != 0) begin
            $display("words never written at %0t: %0d of channel 0, %0d of channel 1",
                     $time, exp_q0.size(), exp_q1.size());
            errors++;
        end
        exp_q0.delete();
        exp_q1.delete();
    endtask

    task automatic match_write(input video_pkg::mem_wr_t wr);
        video_pkg::mem_wr_t want;
        bit                 ch1;
        ch1 = wr.addr >= video_pkg::CH1_BASE;
        if ((ch1 && exp_q1.size() == 0) || (!ch1 && exp_q0.size() == 0)) begin
            $display("unexpected write to address %h at %0t", wr.addr, $time);
            errors++;
        end else begin
            if (ch1) begin
                want = exp_q1.pop_front();
            end else begin
                want = exp_q0.pop_front();
            end
            if (wr !== want) begin
                $display("CHECK FAILED at %0t: write %h/%h, expected %h/%h",
                         $time, wr.addr, wr.data, want.addr, want.data);
                errors++;
            end
        end
    endtask

    // port monitor, sampled half a cycle before the edge that completes a transfer
    always @(negedge sys_clk) begin
        if (sys_rst) begin
            if (prev_valid && !prev_ready && (!mem_valid || mem_wr !== prev_wr)) begin
                $display("CHECK FAILED at %0t: mem_wr changed while mem_ready was low", $time);
                errors++;
            end
            if (mem_valid && mem_ready) begin
                match_write(mem_wr);
            end
        end
        prev_valid = mem_valid;
        prev_ready = mem_ready;
        prev_wr    = mem_wr;
    end

    initial begin
        video_test_t t;
        cmd_test_t   c;
        sys_clk   = 1'b0;
        sys_rst   = 1'b0;
        cam0      = '0;
        cam1      = '0;
        cmd       = '0;
        mem_ready = 1'b0;
        ready_pct = 100;
        errors    = 0;
        repeat (2) @(posedge sys_clk);
        #1;
        sys_rst = 1'b1;
        for (int i = 0; i < $size(video_tests); i++) begin
            t = video_tests[i];
            for (int f = 0; f < t.frames; f++) begin
                ready_pct = t.ready_pct;
                drive_frame(t);
                drain(t.exp_ovf != 0);
            end
            if (overflow0 !== t.exp_ovf[0] || overflow1 !== t.exp_ovf[1]) begin
                $display("CHECK FAILED at %0t: test %0d overflow %b%b, expected %b",
                         $time, i, overflow1, overflow0, t.exp_ovf[1:0]);
                errors++;
            end
        end
        // display registers follow one cycle after the command is sampled
        for (int i = 0; i < $size(cmd_tests); i++) begin
            c = cmd_tests[i];
            step();
            cmd = c.cmd;
            step();
            cmd = '0;
            step();
            if (channel_index !== c.exp_channel || angle_num !== c.exp_angle) begin
                $display("CHECK FAILED at %0t: command %0d gave channel %0d angle %0d",
                         $time, i, channel_index, angle_num);
                errors++;
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog sized from the pixel cycles of the table
    initial begin
        int cycles;
        cycles = 0;
        for (int i = 0; i < $size(video_tests); i++) begin
            cycles += video_tests[i].frames *
                      (video_tests[i].lines * (video_tests[i].pixels + GAP) + 4);
        end
        #((cycles * 4 + 2000) * 4);
        $display("timeout: the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== verilog/video_capture_top.sv ====
// capture top level, two camera samplers feeding the frame writer plus the command decoder
`timescale 1ns/100ps

module video_capture_top (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  video_pkg::video_in_t  cam0,
    input  video_pkg::video_in_t  cam1,
    input  video_pkg::cmd_t       cmd,
    output video_pkg::mem_wr_t    mem_wr,
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output logic                  overflow0,
    output logic                  overflow1,
    output logic [2:0]            channel_index,
    output logic [8:0]            angle_num
);

    video_pkg::pix_word_t word0;
    video_pkg::pix_word_t word1;
    logic                 valid0;
    logic                 valid1;
    logic                 ready0;
    logic                 ready1;

    // camera 0, written at CH0_BASE
    video_sampler i_sampler0 (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .video      (cam0),
        .word       (word0),
        .word_valid (valid0),
        .word_ready (ready0),
        .overflow   (overflow0)
    );

    // camera 1, written at CH1_BASE
    video_sampler i_sampler1 (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .video      (cam1),
        .word       (word1),
        .word_valid (valid1),
        .word_ready (ready1),
        .overflow   (overflow1)
    );

    frame_writer i_frame_writer (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .word0     (word0),
        .word1     (word1),
        .valid0    (valid0),
        .valid1    (valid1),
        .ready0    (ready0),
        .ready1    (ready1),
        .vsync0    (cam0.vsync),
        .vsync1    (cam1.vsync),
        .mem_wr    (mem_wr),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready)
    );

    command_decoder i_command_decoder (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .cmd           (cmd),
        .channel_index (channel_index),
        .angle_num     (angle_num)
    );

endmodule

// ==== verilog/command_decoder.sv ====
// decodes the command port into the focus-channel and rotation-angle display registers
`timescale 1ns/100ps

module command_decoder (
    input  logic              sys_clk,
    input  logic              sys_rst,
    input  video_pkg::cmd_t   cmd,
    output logic [2:0]        channel_index,
    output logic [8:0]        angle_num
);

    // command captured in the cycle its flag is high
    video_pkg::cmd_t cmd_q;

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            cmd_q <= '0;
        end else begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            channel_index <= 3'd0;
            angle_num     <= 9'd0;
        end else if (cmd_q.flag) begin
            // focus value zero keeps the current channel
            if (cmd_q.ctrl == video_pkg::CMD_FOCUS && cmd_q.value != 4'd0) begin
                channel_index <= cmd_q.value[2:0];
            end
            if (cmd_q.ctrl == video_pkg::CMD_ROTATE) begin
                if (cmd_q.value == 4'd1) begin
                    angle_num <= video_pkg::ANGLE_FLIP;
                end else if (cmd_q.value == 4'd0) begin
                    angle_num <= 9'd0;
                end
            end
        end
    end

endmodule

// ==== verilog/frame_writer.sv ====
// round-robin merge of the two camera word streams into one addressed memory write port
`timescale 1ns/100ps

module frame_writer (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  video_pkg::pix_word_t  word0,
    input  video_pkg::pix_word_t  word1,
    input  logic                  valid0,
    input  logic                  valid1,
    output logic                  ready0,
    output logic                  ready1,
    input  logic                  vsync0,
    input  logic                  vsync1,
    output video_pkg::mem_wr_t    mem_wr,
    output logic                  mem_valid,
    input  logic                  mem_ready
);

    logic [1:0]                   vsync_d;
    logic [1:0]                   vsync_rise;
    logic [video_pkg::ADDR_W-1:0] word_cnt [2];
    // high when channel 1 got the last grant
    logic                         last_sel;
    logic                         load_ok;
    logic                         sel1;
    logic [1:0]                   served;
    logic                         take;
    video_pkg::mem_wr_t           next_wr;

    assign vsync_rise = {vsync1, vsync0} & ~vsync_d;

    // output register free, or emptied in this same cycle
    assign load_ok = !mem_valid || mem_ready;

    // on a tie the channel not served last goes first
    assign sel1   = valid1 && (!valid0 || !last_sel);
    assign ready0 = load_ok && valid0 && !sel1;
    assign ready1 = load_ok && sel1;
    assign served = {ready1, ready0};
    assign take   = |served;

    always_comb begin
        if (sel1) begin
            next_wr.addr = video_pkg::CH1_BASE + word_cnt[1];
            next_wr.data = word1;
        end else begin
            next_wr.addr = video_pkg::CH0_BASE + word_cnt[0];
            next_wr.data = word0;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            vsync_d   <= 2'b00;
            mem_valid <= 1'b0;
            last_sel  <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                word_cnt[i] <= '0;
            end
        end else begin
            vsync_d <= {vsync1, vsync0};
            if (load_ok) begin
                mem_valid <= take;
            end
            if (take) begin
                last_sel <= sel1;
            end
            // new frame restarts the word index of that channel
            for (int i = 0; i < 2; i++) begin
                if (vsync_rise[i]) begin
                    word_cnt[i] <= '0;
                end else if (served[i]) begin
                    word_cnt[i] <= word_cnt[i] + 1'b1;
                end
            end
        end
    end

    // held while mem_valid waits for mem_ready
    always_ff @(posedge sys_clk) begin
        if (take) begin
            mem_wr <= next_wr;
        end
    end

endmodule

// ==== verilog/video_sampler.sv ====
// per-camera 1/16 decimation, packing of kept pixels into words and word queue toward the writer
`timescale 1ns/100ps

module video_sampler (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  video_pkg::video_in_t  video,
    output video_pkg::pix_word_t  word,
    output logic                  word_valid,
    input  logic                  word_ready,
    output logic                  overflow
);

    logic                                        vsync_d;
    logic                                        de_d;
    logic                                        vsync_rise;
    logic                                        de_fall;
    logic [$clog2(video_pkg::DECIM)-1:0]         pix_cnt;
    logic [$clog2(video_pkg::DECIM)-1:0]         line_cnt;
    logic [$clog2(video_pkg::PIX_PER_WORD)-1:0]  kept_cnt;
    logic                                        keep;
    video_pkg::pix_word_t                        pack;
    logic                                        word_done;
    logic                                        fifo_full;
    logic                                        fifo_empty;

    assign vsync_rise = video.vsync && !vsync_d;
    assign de_fall    = de_d && !video.de;

    // first pixel of every DECIM-th line and every DECIM-th pixel within it
    assign keep = video.de && (pix_cnt == 0) && (line_cnt == 0);

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            vsync_d   <= 1'b0;
            de_d      <= 1'b0;
            pix_cnt   <= '0;
            line_cnt  <= '0;
            kept_cnt  <= '0;
            word_done <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            vsync_d   <= video.vsync;
            de_d      <= video.de;
            word_done <= 1'b0;
            if (!video.de || pix_cnt == video_pkg::DECIM - 1) begin
                pix_cnt <= '0;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            if (vsync_rise) begin
                line_cnt <= '0;
            end else if (de_fall) begin
                line_cnt <= (line_cnt == video_pkg::DECIM - 1) ? '0 : line_cnt + 1'b1;
            end
            // a partial group is dropped when a new frame starts
            if (vsync_rise) begin
                kept_cnt <= '0;
            end else if (keep) begin
                if (kept_cnt == video_pkg::PIX_PER_WORD - 1) begin
                    kept_cnt  <= '0;
                    word_done <= 1'b1;
                end else begin
                    kept_cnt <= kept_cnt + 1'b1;
                end
            end
            if (word_done && fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    // shift in from the top so the oldest pixel ends up lowest
    always_ff @(posedge sys_clk) begin
        if (keep) begin
            pack <= {video.pix, pack[$bits(video_pkg::pix_word_t)-1:$bits(video_pkg::pix_t)]};
        end
    end

    sync_fifo #(
        .payload_t (video_pkg::pix_word_t),
        .depth     (video_pkg::FIFO_DEPTH)
    ) i_word_fifo (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .push      (word_done),
        .push_data (pack),
        .full      (fifo_full),
        .pop       (word_ready),
        .pop_data  (word),
        .empty     (fifo_empty)
    );

    assign word_valid = !fifo_empty;

endmodule

// ==== verilog/sync_fifo.sv ====
// single-clock first-word-fall-through FIFO, payload type chosen per instance
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 8
) (
    input  logic     sys_clk,
    input  logic     sys_rst,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    payload_t                     mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth+1)-1:0]   count;
    logic                         do_push;
    logic                         do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == depth);
    assign empty    = (count == 0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at depth, so depth need not be a power of two
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/video_pkg.sv ====
// shared pixel, word, memory-write and command types plus sizing constants for the capture path
package video_pkg;

    // pixels per memory word and decimation step
    localparam int PIX_PER_WORD = 4;
    localparam int DECIM        = 4;

    // word address width of the write port
    localparam int ADDR_W = 20;

    // frame base word addresses, one region per camera
    localparam logic [ADDR_W-1:0] CH0_BASE = 20'h00000;
    localparam logic [ADDR_W-1:0] CH1_BASE = 20'h40000;

    // words buffered in each sampler
    localparam int FIFO_DEPTH = 8;

    // command port ctrl codes
    localparam logic [3:0] CMD_FOCUS  = 4'hF;
    localparam logic [3:0] CMD_ROTATE = 4'h3;

    // angle shown when the image is flipped
    localparam logic [8:0] ANGLE_FLIP = 9'd180;

    // one rgb565 pixel
    typedef logic [15:0] pix_t;

    // camera input, one pixel per cycle while de is high
    typedef struct packed {
        logic vsync;
        logic de;
        pix_t pix;
    } video_in_t;

    // four pixels, first kept pixel in the low 16 bits
    typedef logic [PIX_PER_WORD*16-1:0] pix_word_t;

    // addressed word on the memory write port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        pix_word_t         data;
    } mem_wr_t;

    // command port, valid while flag is high
    typedef struct packed {
        logic       flag;
        logic [3:0] ctrl;
        logic [3:0] value;
    } cmd_t;

endpackage
